/* rtl/can_pkg.sv */
// Shared constants for the receive-only CAN front end; FIFO_DEPTH must equal 2**FIFO_AW
`default_nettype none

package can_pkg;

  //////////////////////////////////////////////////
  // Host interface
  //////////////////////////////////////////////////
  localparam int DATA_W = 8;
  localparam int ADDR_W = 3;

  // Register map
  localparam logic [ADDR_W-1:0] ADDR_MODE   = 3'd0;
  localparam logic [ADDR_W-1:0] ADDR_CMD    = 3'd1;
  localparam logic [ADDR_W-1:0] ADDR_STATUS = 3'd2;
  localparam logic [ADDR_W-1:0] ADDR_BTR0   = 3'd3;
  localparam logic [ADDR_W-1:0] ADDR_BTR1   = 3'd4;
  localparam logic [ADDR_W-1:0] ADDR_RXDATA = 3'd5;

  // Bit positions inside mode, command and status
  localparam int MODE_RESET      = 0;
  localparam int MODE_RXIE       = 1;
  localparam int CMD_RELEASE     = 0;
  localparam int CMD_CLR_OVERRUN = 1;
  localparam int CMD_CLR_ERROR   = 2;
  localparam int ST_RXFULL       = 0;
  localparam int ST_OVERRUN      = 1;
  localparam int ST_RECEIVING    = 2;
  localparam int ST_STUFFERR     = 3;

  //////////////////////////////////////////////////
  // Bit timing
  //////////////////////////////////////////////////
  localparam int PRESC_W = 6;
  localparam int TSEG1_W = 4;
  localparam int TSEG2_W = 3;
  // Clock count within one quantum, up to 2*(presc+1)-1
  localparam int CLK_W   = PRESC_W + 1;
  // Quantum index within one bit, up to 15+7+2
  localparam int TQ_W    = 5;

  //////////////////////////////////////////////////
  // Receive path
  //////////////////////////////////////////////////
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = 3;
  localparam int BIT_CNT_W  = 3;
  localparam int RUN_W      = 3;
  // Five equal bits force a stuff bit
  localparam logic [RUN_W-1:0] STUFF_RUN = 3'd5;
  // Six recessive bits end a frame or leave the error state
  localparam logic [RUN_W-1:0] END_RUN   = 3'd6;

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    RECEIVE = 2'd1,
    ERROR   = 2'd2
  } rx_state_t;

endpackage

`default_nettype wire

/* rtl/can_bit_timing.sv */
// Bit timing without resync or SJW; counters held cleared in reset mode, hard sync only when idle
`default_nettype none
`timescale 1ns/100ps

module can_bit_timing (
  input  wire                        clk_i,
  input  wire                        rst,
  input  wire                        rx_i,
  input  wire [can_pkg::PRESC_W-1:0] presc_i,
  input  wire [can_pkg::TSEG1_W-1:0] tseg1_i,
  input  wire [can_pkg::TSEG2_W-1:0] tseg2_i,
  input  wire                        bus_idle_i,
  input  wire                        reset_mode_i,
  output logic                       sample_point_o,
  output logic                       sampled_bit_o
);
  import can_pkg::*;

  logic            rx_meta;
  logic            rx_sync;
  logic            rx_prev;
  logic [CLK_W-1:0] clk_cnt;
  logic [TQ_W-1:0] tq_cnt;
  logic [TQ_W-1:0] sample_tq;
  logic [TQ_W-1:0] last_tq;
  logic            tq_tick;
  logic            hard_sync;
  logic            sample_now;

  //////////////////////////////////////////////////
  // Input synchroniser
  //////////////////////////////////////////////////

  // Bus idles recessive, so flops reset to 1
  // rx_prev only serves the falling edge detect
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // Falling edge on the synced line while no frame runs
  assign hard_sync = bus_idle_i & rx_prev & ~rx_sync;

  //////////////////////////////////////////////////
  // Quantum and segment counters
  //////////////////////////////////////////////////

  // One quantum is 2*(presc+1) clocks
  assign tq_tick = (clk_cnt == {presc_i, 1'b1});

  // Quantum 0 is the sync segment, then tseg1+1 and tseg2+1 quanta
  assign sample_tq = TQ_W'(tseg1_i) + TQ_W'(1);
  assign last_tq   = TQ_W'(tseg1_i) + TQ_W'(tseg2_i) + TQ_W'(2);

  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      clk_cnt <= '0;
      tq_cnt  <= '0;
    end
    else if (reset_mode_i || hard_sync)
    begin
      // Restart the bit at its sync segment
      clk_cnt <= '0;
      tq_cnt  <= '0;
    end
    else if (tq_tick)
    begin
      clk_cnt <= '0;
      if (tq_cnt == last_tq)
        tq_cnt <= '0;
      else
        tq_cnt <= tq_cnt + TQ_W'(1);
    end
    else
    begin
      clk_cnt <= clk_cnt + CLK_W'(1);
    end
  end

  // Sample at the end of tseg1
  assign sample_now = tq_tick & (tq_cnt == sample_tq) & ~reset_mode_i & ~hard_sync;

  // Pulse and bit leave together, one cycle after the last tseg1 clock
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      sample_point_o <= 1'b0;
      sampled_bit_o  <= 1'b1;
    end
    else
    begin
      sample_point_o <= sample_now;
      if (sample_now)
        sampled_bit_o <= rx_sync;
    end
  end

  // A bit is at least three quanta of two clocks
  a_sample_single: assert property (@(posedge clk_i) disable iff (rst)
    sample_point_o |=> !sample_point_o);

endmodule

`default_nettype wire

/* rtl/can_rx_fsm.sv */
// Receive FSM with destuffing; the start-of-frame bit counts in the first run, no CRC or fields
`default_nettype none
`timescale 1ns/100ps

module can_rx_fsm (
  input  wire                clk_i,
  input  wire                rst,
  input  wire                sample_point_i,
  input  wire                sampled_bit_i,
  input  wire                reset_mode_i,
  output logic               bus_idle_o,
  output logic               shift_en_o,
  output logic               clear_bits_o,
  output logic               frame_active_o,
  output can_pkg::rx_state_t state_o
);
  import can_pkg::*;

  rx_state_t        state_q;
  logic [RUN_W-1:0] run_cnt;
  logic             last_bit;
  logic             same_bit;
  logic             run_full;

  assign same_bit = (sampled_bit_i == last_bit);
  assign run_full = (run_cnt == STUFF_RUN);

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////
  assign state_o        = state_q;
  assign bus_idle_o     = (state_q == IDLE);
  assign frame_active_o = (state_q == RECEIVE);

  // Every bit of a frame is payload unless it follows a full run
  assign shift_en_o = sample_point_i & frame_active_o & ~run_full & ~reset_mode_i;

  // Drop any partial byte at start of frame, at end of frame and on stuff error
  assign clear_bits_o = sample_point_i &
                        ((bus_idle_o & ~sampled_bit_i) |
                         (frame_active_o & run_full & same_bit));

  //////////////////////////////////////////////////
  // State and run-length counter
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      state_q  <= IDLE;
      run_cnt  <= '0;
      last_bit <= 1'b1;
    end
    else if (reset_mode_i)
    begin
      state_q  <= IDLE;
      run_cnt  <= '0;
      last_bit <= 1'b1;
    end
    else if (sample_point_i)
    begin
      case (state_q)
        IDLE:
        begin
          // Dominant sample is the start of frame
          if (!sampled_bit_i)
          begin
            state_q  <= RECEIVE;
            run_cnt  <= RUN_W'(1);
            last_bit <= 1'b0;
          end
        end
        RECEIVE:
        begin
          if (!same_bit)
          begin
            // New run; after a full run this is the dropped stuff bit
            run_cnt  <= RUN_W'(1);
            last_bit <= sampled_bit_i;
          end
          else if (run_full)
          begin
            // Sixth equal bit: recessive ends the frame, dominant is a stuff error
            state_q  <= sampled_bit_i ? IDLE : ERROR;
            run_cnt  <= '0;
            last_bit <= 1'b1;
          end
          else
          begin
            run_cnt <= run_cnt + RUN_W'(1);
          end
        end
        ERROR:
        begin
          // Wait for END_RUN recessive bits in a row
          if (!sampled_bit_i)
            run_cnt <= '0;
          else if (run_cnt == END_RUN - RUN_W'(1))
          begin
            state_q <= IDLE;
            run_cnt <= '0;
          end
          else
            run_cnt <= run_cnt + RUN_W'(1);
        end
        default:
        begin
          state_q <= IDLE;
          run_cnt <= '0;
        end
      endcase
    end
  end

  // Destuff run stays between one and STUFF_RUN for the whole frame
  a_run_in_frame: assert property (@(posedge clk_i) disable iff (rst)
    state_q == RECEIVE |-> run_cnt != '0 && run_cnt <= STUFF_RUN);

endmodule

`default_nettype wire

/* rtl/can_rx_deserializer.sv */
// Packs payload bits MSB first into bytes; a partial byte at frame end is discarded
`default_nettype none
`timescale 1ns/100ps

module can_rx_deserializer (
  input  wire                       clk_i,
  input  wire                       rst,
  input  wire                       sampled_bit_i,
  input  wire                       shift_en_i,
  input  wire                       clear_bits_i,
  input  wire                       frame_active_i,
  output logic                      byte_valid_o,
  output logic [can_pkg::DATA_W-1:0] byte_data_o
);
  import can_pkg::*;

  logic [BIT_CNT_W-1:0] bit_cnt;
  logic [DATA_W-1:0]    shift_q;
  logic                 take_bit;

  assign take_bit = shift_en_i & frame_active_i;

  // Bit counter wraps after eight bits and flags the byte
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      bit_cnt      <= '0;
      byte_valid_o <= 1'b0;
    end
    else
    begin
      byte_valid_o <= 1'b0;
      if (clear_bits_i)
        bit_cnt <= '0;
      else if (take_bit)
      begin
        bit_cnt      <= bit_cnt + BIT_CNT_W'(1);
        byte_valid_o <= (bit_cnt == '1);
      end
    end
  end

  // Payload shift register, first bit ends up in the MSB
  always_ff @(posedge clk_i)
  begin
    if (take_bit)
      shift_q <= {shift_q[DATA_W-2:0], sampled_bit_i};
  end

  assign byte_data_o = shift_q;

endmodule

`default_nettype wire

/* rtl/can_rx_fifo.sv */
// Receive byte FIFO; a byte written while full is dropped and sets the sticky overrun flag
`default_nettype none
`timescale 1ns/100ps

module can_rx_fifo (
  input  wire                        clk_i,
  input  wire                        rst,
  input  wire                        flush_i,
  input  wire                        wr_i,
  input  wire [can_pkg::DATA_W-1:0]  wr_data_i,
  input  wire                        release_i,
  input  wire                        clr_overrun_i,
  output logic [can_pkg::DATA_W-1:0] rd_data_o,
  output logic                       not_empty_o,
  output logic                       overrun_o
);
  import can_pkg::*;

  logic [DATA_W-1:0]  mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               full;
  logic               do_wr;
  logic               do_rd;

  // Depth is a power of two, so the count MSB means full
  assign full        = count[FIFO_AW];
  assign not_empty_o = (count != '0);
  assign do_wr       = wr_i & ~full & ~flush_i;
  assign do_rd       = release_i & not_empty_o & ~flush_i;

  //////////////////////////////////////////////////
  // Pointers and count
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else if (flush_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + FIFO_AW'(1);
      // Release advances the head
      if (do_rd)
        rd_ptr <= rd_ptr + FIFO_AW'(1);
      if (do_wr && !do_rd)
        count <= count + (FIFO_AW+1)'(1);
      else if (do_rd && !do_wr)
        count <= count - (FIFO_AW+1)'(1);
    end
  end

  // Set wins over a clear in the same cycle
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
      overrun_o <= 1'b0;
    else if (flush_i)
      overrun_o <= 1'b0;
    else if (wr_i && full)
      overrun_o <= 1'b1;
    else if (clr_overrun_i)
      overrun_o <= 1'b0;
  end

  // Byte storage
  always_ff @(posedge clk_i)
  begin
    if (do_wr)
      mem[wr_ptr] <= wr_data_i;
  end

  // Head of the FIFO, shown without a read strobe
  assign rd_data_o = mem[rd_ptr];

  a_count_bound: assert property (@(posedge clk_i) disable iff (rst)
    count <= FIFO_DEPTH);

endmodule

`default_nettype wire

/* rtl/can_registers.sv */
// Host registers on one address port; bus timing writes only take effect in reset mode
`default_nettype none
`timescale 1ns/100ps

module can_registers (
  input  wire                         clk_i,
  input  wire                         rst,
  input  wire                         reg_we_i,
  input  wire                         reg_re_i,
  input  wire [can_pkg::ADDR_W-1:0]   reg_addr_i,
  input  wire [can_pkg::DATA_W-1:0]   reg_data_i,
  output logic [can_pkg::DATA_W-1:0]  reg_data_o,
  input  can_pkg::rx_state_t          state_i,
  input  wire [can_pkg::DATA_W-1:0]   rx_data_i,
  input  wire                         not_empty_i,
  input  wire                         overrun_i,
  output logic                        reset_mode_o,
  output logic [can_pkg::PRESC_W-1:0] presc_o,
  output logic [can_pkg::TSEG1_W-1:0] tseg1_o,
  output logic [can_pkg::TSEG2_W-1:0] tseg2_o,
  output logic                        release_o,
  output logic                        clr_overrun_o,
  output logic                        clr_error_o,
  output logic                        irq_n_o
);
  import can_pkg::*;

  logic [MODE_RXIE:0] mode_q;
  logic               stuff_err_q;
  logic               cmd_we;
  logic [DATA_W-1:0]  status;
  logic [DATA_W-1:0]  rd_mux;

  assign reset_mode_o = mode_q[MODE_RESET];
  assign cmd_we       = reg_we_i && (reg_addr_i == ADDR_CMD);

  //////////////////////////////////////////////////
  // Mode and bus timing
  //////////////////////////////////////////////////

  // Leaves reset in reset mode with the interrupt masked
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      mode_q  <= 2'b01;
      presc_o <= '0;
      tseg1_o <= '0;
      tseg2_o <= '0;
    end
    else if (reg_we_i)
    begin
      if (reg_addr_i == ADDR_MODE)
        mode_q <= reg_data_i[MODE_RXIE:0];
      // BTR0 upper bits held the dropped SJW field
      if (reg_addr_i == ADDR_BTR0 && reset_mode_o)
        presc_o <= reg_data_i[PRESC_W-1:0];
      // BTR1 keeps tseg1 low, tseg2 above it, bit 7 unused
      if (reg_addr_i == ADDR_BTR1 && reset_mode_o)
      begin
        tseg1_o <= reg_data_i[TSEG1_W-1:0];
        tseg2_o <= reg_data_i[TSEG1_W +: TSEG2_W];
      end
    end
  end

  //////////////////////////////////////////////////
  // Command pulses and stuff error
  //////////////////////////////////////////////////

  // One cycle per set command bit
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      release_o     <= 1'b0;
      clr_overrun_o <= 1'b0;
      clr_error_o   <= 1'b0;
    end
    else
    begin
      release_o     <= cmd_we & reg_data_i[CMD_RELEASE];
      clr_overrun_o <= cmd_we & reg_data_i[CMD_CLR_OVERRUN];
      clr_error_o   <= cmd_we & reg_data_i[CMD_CLR_ERROR];
    end
  end

  // Sticky while the FSM sits in ERROR, so a clear only holds after recovery
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
      stuff_err_q <= 1'b0;
    else if (state_i == ERROR)
      stuff_err_q <= 1'b1;
    else if (clr_error_o)
      stuff_err_q <= 1'b0;
  end

  //////////////////////////////////////////////////
  // Status and read port
  //////////////////////////////////////////////////
  always_comb
  begin
    status               = '0;
    // Receive buffer holds at least one byte
    status[ST_RXFULL]    = not_empty_i;
    status[ST_OVERRUN]   = overrun_i;
    status[ST_RECEIVING] = (state_i == RECEIVE);
    // Error shows from the first ERROR cycle
    status[ST_STUFFERR]  = stuff_err_q | (state_i == ERROR);
  end

  always_comb
  begin
    case (reg_addr_i)
      ADDR_MODE:   rd_mux = DATA_W'(mode_q);
      ADDR_STATUS: rd_mux = status;
      ADDR_BTR0:   rd_mux = DATA_W'(presc_o);
      ADDR_BTR1:   rd_mux = DATA_W'({tseg2_o, tseg1_o});
      ADDR_RXDATA: rd_mux = rx_data_i;
      // Command register reads as zero
      default:     rd_mux = '0;
    endcase
  end

  // Read data holds until the next read strobe
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
      reg_data_o <= '0;
    else if (reg_re_i)
      reg_data_o <= rd_mux;
  end

  // Active low, level while enabled bytes wait
  assign irq_n_o = ~(mode_q[MODE_RXIE] & not_empty_i);

endmodule

`default_nettype wire

/* rtl/can_top.sv */
// Receive-only CAN front end top; rx_i is asynchronous, host side runs on clk_i
`default_nettype none
`timescale 1ns/100ps

module can_top (
  input  wire                        clk_i,
  input  wire                        rst,
  input  wire                        reg_we_i,
  input  wire                        reg_re_i,
  input  wire [can_pkg::ADDR_W-1:0]  reg_addr_i,
  input  wire [can_pkg::DATA_W-1:0]  reg_data_i,
  output logic [can_pkg::DATA_W-1:0] reg_data_o,
  input  wire                        rx_i,
  output logic                       irq_n_o
);
  import can_pkg::*;

  // Registers to the receive path
  logic               reset_mode;
  logic [PRESC_W-1:0] presc;
  logic [TSEG1_W-1:0] tseg1;
  logic [TSEG2_W-1:0] tseg2;
  logic               release_buffer;
  logic               clr_overrun;

  // Bit timing and FSM
  logic               sample_point;
  logic               sampled_bit;
  logic               bus_idle;
  logic               shift_en;
  logic               clear_bits;
  logic               frame_active;
  rx_state_t          state;

  // Bytes and FIFO
  logic               byte_valid;
  logic [DATA_W-1:0]  byte_data;
  logic [DATA_W-1:0]  rx_data;
  logic               not_empty;
  logic               overrun;

  can_bit_timing i_can_bit_timing (
    .clk_i          (clk_i),
    .rst            (rst),
    .rx_i           (rx_i),
    .presc_i        (presc),
    .tseg1_i        (tseg1),
    .tseg2_i        (tseg2),
    .bus_idle_i     (bus_idle),
    .reset_mode_i   (reset_mode),
    .sample_point_o (sample_point),
    .sampled_bit_o  (sampled_bit)
  );

  can_rx_fsm i_can_rx_fsm (
    .clk_i          (clk_i),
    .rst            (rst),
    .sample_point_i (sample_point),
    .sampled_bit_i  (sampled_bit),
    .reset_mode_i   (reset_mode),
    .bus_idle_o     (bus_idle),
    .shift_en_o     (shift_en),
    .clear_bits_o   (clear_bits),
    .frame_active_o (frame_active),
    .state_o        (state)
  );

  can_rx_deserializer i_can_rx_deserializer (
    .clk_i          (clk_i),
    .rst            (rst),
    .sampled_bit_i  (sampled_bit),
    .shift_en_i     (shift_en),
    .clear_bits_i   (clear_bits),
    .frame_active_i (frame_active),
    .byte_valid_o   (byte_valid),
    .byte_data_o    (byte_data)
  );

  // Reset mode empties the FIFO
  can_rx_fifo i_can_rx_fifo (
    .clk_i          (clk_i),
    .rst            (rst),
    .flush_i        (reset_mode),
    .wr_i           (byte_valid),
    .wr_data_i      (byte_data),
    .release_i      (release_buffer),
    .clr_overrun_i  (clr_overrun),
    .rd_data_o      (rx_data),
    .not_empty_o    (not_empty),
    .overrun_o      (overrun)
  );

  // Clear-error pulse only acts inside the register block
  can_registers i_can_registers (
    .clk_i          (clk_i),
    .rst            (rst),
    .reg_we_i       (reg_we_i),
    .reg_re_i       (reg_re_i),
    .reg_addr_i     (reg_addr_i),
    .reg_data_i     (reg_data_i),
    .reg_data_o     (reg_data_o),
    .state_i        (state),
    .rx_data_i      (rx_data),
    .not_empty_i    (not_empty),
    .overrun_i      (overrun),
    .reset_mode_o   (reset_mode),
    .presc_o        (presc),
    .tseg1_o        (tseg1),
    .tseg2_o        (tseg2),
    .release_o      (release_buffer),
    .clr_overrun_o  (clr_overrun),
    .clr_error_o    (),
    .irq_n_o        (irq_n_o)
  );

endmodule

`default_nettype wire

/* verif/can_tb.sv */
// Testbench for the CAN receive front end; one fixed bit timing, needs --timing and --assert
`default_nettype none
`timescale 1ns/100ps

module can_tb;
  import can_pkg::*;

  // Bus timing programmed in test 2, used by the bus model
  localparam int PRESC      = 1;
  localparam int TSEG1      = 4;
  localparam int TSEG2      = 2;
  localparam int BIT_CLKS   = 2 * (PRESC + 1) * (3 + TSEG1 + TSEG2);
  localparam int IDLE_BITS  = 8;
  // Ten bus bits per byte at most with stuffing, plus SOF, idle and the error run
  localparam int RX_BITS    = (4 + 9 + 2) * 10 + 3 * (1 + IDLE_BITS) + 16;
  localparam int MAX_CYCLES = 2 * RX_BITS * BIT_CLKS + 2000;

  logic              clk_i;
  logic              rst;
  logic              reg_we_i;
  logic              reg_re_i;
  logic [ADDR_W-1:0] reg_addr_i;
  logic [DATA_W-1:0] reg_data_i;
  logic [DATA_W-1:0] reg_data_o;
  logic              rx_i;
  logic              irq_n_o;

  // Check strobes and expected values seen by the assertions
  logic              chk_rd;
  logic [DATA_W-1:0] exp_rd;
  logic              chk_irq;
  logic              exp_irq;
  logic [DATA_W-1:0] exp_q[$];
  logic [DATA_W-1:0] frame_q[$];

  logic [31:0]       rng_state;
  int                cycle_cnt = 0;
  int                err_cnt;
  int                err_base;
  int                tests_pass;
  int                tests_fail;
  string             cur_name;

  can_top i_can_top (
    .clk_i      (clk_i),
    .rst        (rst),
    .reg_we_i   (reg_we_i),
    .reg_re_i   (reg_re_i),
    .reg_addr_i (reg_addr_i),
    .reg_data_i (reg_data_i),
    .reg_data_o (reg_data_o),
    .rx_i       (rx_i),
    .irq_n_o    (irq_n_o)
  );

  // 8 ns clock
  always #4 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Read data already latched one cycle before the strobe
  a_read_data: assert property (@(posedge clk_i) chk_rd |-> reg_data_o == exp_rd)
    else
    begin
      err_cnt++;
      $display("error at %0t: read data %h, expected %h", $time, $sampled(reg_data_o),
               exp_rd);
    end

  a_irq_level: assert property (@(posedge clk_i) chk_irq |-> irq_n_o == exp_irq)
    else
    begin
      err_cnt++;
      $display("error at %0t: irq_n_o is %b, expected %b", $time, $sampled(irq_n_o), exp_irq);
    end

  // Run limit from the frame lengths
  always @(posedge clk_i)
  begin
    cycle_cnt++;
    if (cycle_cnt == MAX_CYCLES)
    begin
      $display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic begin_test(input string name);
    cur_name = name;
    err_base = err_cnt;
  endtask

  task automatic finish_test();
    if (err_cnt == err_base)
    begin
      tests_pass++;
      $display("test %s: pass", cur_name);
    end
    else
    begin
      tests_fail++;
      $display("test %s: FAIL with %0d errors", cur_name, err_cnt - err_base);
    end
  endtask

  // Command pulse follows one cycle later, its effect one more
  task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    @(negedge clk_i);
    reg_we_i   = 1'b1;
    reg_addr_i = addr;
    reg_data_i = data;
    @(negedge clk_i);
    reg_we_i = 1'b0;
    repeat (2) @(negedge clk_i);
  endtask

  // Read strobe, then check against the queue head in the next cycle
  task automatic read_check(input logic [ADDR_W-1:0] addr);
    @(negedge clk_i);
    reg_re_i   = 1'b1;
    reg_addr_i = addr;
    @(negedge clk_i);
    reg_re_i = 1'b0;
    if (exp_q.size() == 0)
    begin
      err_cnt++;
      $display("read at %0t has no expected value queued", $time);
    end
    else
    begin
      exp_rd = exp_q.pop_front();
      chk_rd = 1'b1;
      @(negedge clk_i);
      chk_rd = 1'b0;
    end
  endtask

  task automatic expect_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] value);
    exp_q.push_back(value);
    read_check(addr);
  endtask

  task automatic check_irq(input logic value);
    @(negedge clk_i);
    exp_irq = value;
    chk_irq = 1'b1;
    @(negedge clk_i);
    chk_irq = 1'b0;
  endtask

  // Pops the first n frame bytes in order, release after each
  task automatic read_bytes(input int n);
    int i;
    for (i = 0; i < n; i++)
    begin
      exp_q.push_back(frame_q[i]);
      read_check(ADDR_RXDATA);
      reg_write(ADDR_CMD, DATA_W'(1 << CMD_RELEASE));
    end
  endtask

  task automatic gen_payload(input int n);
    int i;
    frame_q.delete();
    for (i = 0; i < n; i++)
    begin
      rng_state = xorshift(rng_state);
      frame_q.push_back(rng_state[7:0]);
    end
  endtask

  //////////////////////////////////////////////////
  // Bus model
  //////////////////////////////////////////////////
  task automatic drive_bit(input logic b);
    @(negedge clk_i);
    rx_i = b;
    repeat (BIT_CLKS - 1) @(negedge clk_i);
  endtask

  // SOF, payload MSB first with stuffing, then recessive idle
  task automatic send_frame();
    int   i;
    int   k;
    int   run;
    logic last;
    logic b;
    drive_bit(1'b0);
    last = 1'b0;
    run  = 1;
    for (i = 0; i < frame_q.size(); i++)
    begin
      for (k = DATA_W - 1; k >= 0; k--)
      begin
        b = frame_q[i][k];
        drive_bit(b);
        if (b == last)
          run++;
        else
        begin
          run  = 1;
          last = b;
        end
        // Five equal bits, the stuff bit starts the next run
        if (run == 5)
        begin
          drive_bit(~last);
          last = ~last;
          run  = 1;
        end
      end
    end
    repeat (IDLE_BITS) drive_bit(1'b1);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial
  begin
    clk_i      = 1'b0;
    rst        = 1'b1;
    reg_we_i   = 1'b0;
    reg_re_i   = 1'b0;
    reg_addr_i = '0;
    reg_data_i = '0;
    rx_i       = 1'b1;
    chk_rd     = 1'b0;
    exp_rd     = '0;
    chk_irq    = 1'b0;
    exp_irq    = 1'b1;
    rng_state  = 32'h8b3f;
    err_cnt    = 0;
    err_base   = 0;
    tests_pass = 0;
    tests_fail = 0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst = 1'b0;

    begin_test("reset values");
    expect_reg(ADDR_MODE, DATA_W'(1 << MODE_RESET));
    expect_reg(ADDR_STATUS, 8'h00);
    check_irq(1'b1);
    finish_test();

    begin_test("bus timing registers");
    reg_write(ADDR_BTR0, DATA_W'(PRESC));
    reg_write(ADDR_BTR1, DATA_W'((TSEG2 << TSEG1_W) | TSEG1));
    expect_reg(ADDR_BTR0, DATA_W'(PRESC));
    expect_reg(ADDR_BTR1, DATA_W'((TSEG2 << TSEG1_W) | TSEG1));
    reg_write(ADDR_MODE, 8'h00);
    expect_reg(ADDR_MODE, 8'h00);
    // Ignored outside reset mode
    reg_write(ADDR_BTR0, 8'h3f);
    reg_write(ADDR_BTR1, 8'h7f);
    expect_reg(ADDR_BTR0, DATA_W'(PRESC));
    expect_reg(ADDR_BTR1, DATA_W'((TSEG2 << TSEG1_W) | TSEG1));
    finish_test();

    begin_test("stuffed frame");
    gen_payload(4);
    // Five zero bits in a row force a stuff bit
    frame_q[1] = frame_q[1] & 8'hc1;
    fork
      send_frame();
      begin
        repeat (4 * BIT_CLKS) @(negedge clk_i);
        expect_reg(ADDR_STATUS, DATA_W'(1 << ST_RECEIVING));
      end
    join
    expect_reg(ADDR_STATUS, DATA_W'(1 << ST_RXFULL));
    read_bytes(4);
    expect_reg(ADDR_STATUS, 8'h00);
    finish_test();

    begin_test("overrun");
    gen_payload(9);
    send_frame();
    expect_reg(ADDR_STATUS, DATA_W'((1 << ST_RXFULL) | (1 << ST_OVERRUN)));
    reg_write(ADDR_CMD, DATA_W'(1 << CMD_CLR_OVERRUN));
    expect_reg(ADDR_STATUS, DATA_W'(1 << ST_RXFULL));
    // Ninth byte was dropped
    read_bytes(FIFO_DEPTH);
    expect_reg(ADDR_STATUS, 8'h00);
    finish_test();

    begin_test("stuff error");
    repeat (6) drive_bit(1'b0);
    repeat (2) drive_bit(1'b1);
    expect_reg(ADDR_STATUS, DATA_W'(1 << ST_STUFFERR));
    // Six recessive bits in total let the FSM leave ERROR
    repeat (6) drive_bit(1'b1);
    reg_write(ADDR_CMD, DATA_W'(1 << CMD_CLR_ERROR));
    expect_reg(ADDR_STATUS, 8'h00);
    finish_test();

    begin_test("receive interrupt");
    reg_write(ADDR_MODE, DATA_W'(1 << MODE_RXIE));
    check_irq(1'b1);
    gen_payload(2);
    fork
      send_frame();
      begin
        while (irq_n_o)
          @(negedge clk_i);
      end
    join
    check_irq(1'b0);
    read_bytes(2);
    check_irq(1'b1);
    finish_test();

    $display("tests: %0d passed, %0d failed, %0d errors", tests_pass, tests_fail, err_cnt);
    if (tests_fail == 0 && err_cnt == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
rtl/can_pkg.sv
rtl/can_bit_timing.sv
rtl/can_rx_fsm.sv
rtl/can_rx_deserializer.sv
rtl/can_rx_fifo.sv
rtl/can_registers.sv
rtl/can_top.sv
verif/can_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the CAN receive testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module can_tb -f all.f --Mdir obj_dir -o can_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/can_tb_sim)
sim_status=$?
printf '%s\n' "$out"
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^Simulation passed$"; then
  exit 0
fi
echo "Pass message not found in simulator output"
exit 1
